// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the AHB-Lite subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tbAhbSubsystem -f sources.f -o simTb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output="$(./obj_dir/simTb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "all tests passed"; then
  exit 0
fi
exit 1

// ==== sources.f ====
src/ahbPkg.sv
src/ahbWriteStage.sv
src/ahbBusUnit.sv
src/ahbSram.sv
src/ahbSubsystem.sv
tests/tbAhbSubsystem.sv

// ==== src/ahbBusUnit.sv ====
// AHB-Lite external bus unit
// Arbitrates instruction fetch and load/store streams onto one manager port
// Data streams win from idle, an ongoing fetch is never preempted

`timescale 1ns/1ps

module ahbBusUnit import ahbPkg::*; #(
  parameter int DataBits = 32
) (
  input  logic                  clk,
  input  logic                  arstN,
  // Instruction fetch requester
  input  busReqT                ifuReq,
  input  logic                  ifuBusRead,
  input  logic                  ifuTransComplete,
  output logic                  ifuBusInit,
  output logic                  ifuBusAck,
  // Load/store requester
  input  busReqT                lsuReq,
  input  logic [DataBits-1:0]   lsuWdata,
  input  logic                  lsuBusRead,
  input  logic                  lsuBusWrite,
  input  logic                  lsuTransComplete,
  output logic                  lsuBusInit,
  output logic                  lsuBusAck,
  // AHB-Lite manager side
  input  logic                  hready,
  output ahbCtrlT               ctrl,
  output logic [DataBits-1:0]   hwdata,
  output logic [DataBits/8-1:0] hwstrb
);

  busStateT              state;
  busStateT              nextState;
  logic                  lsuGrant;
  logic                  lsuOwned;
  logic                  ifuOwned;
  logic                  writeDataPhase;
  logic [DataBits/8-1:0] laneStrb;

  //////////////////////////////////////////////////////////////////////
  // Ownership FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // Loads beat stores, both beat fetches
  // A finishing owner hands over in the same cycle
  always_comb begin
    case (state)
      Idle: begin
        if (lsuBusRead)       nextState = MemRead;
        else if (lsuBusWrite) nextState = MemWrite;
        else if (ifuBusRead)  nextState = InstrRead;
        else                  nextState = Idle;
      end
      MemRead, MemWrite: begin
        if (!lsuTransComplete) nextState = state;
        else if (ifuBusRead)   nextState = InstrRead;
        else                   nextState = Idle;
      end
      InstrRead: begin
        if (!ifuTransComplete) nextState = InstrRead;
        else if (lsuBusRead)   nextState = MemRead;
        else if (lsuBusWrite)  nextState = MemWrite;
        else                   nextState = Idle;
      end
      default: nextState = Idle;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Address-phase mux
  //////////////////////////////////////////////////////////////////////

  // Selection follows the next owner so the first beat goes out with init
  assign lsuGrant = (nextState == MemRead) || (nextState == MemWrite);

  always_comb begin
    ctrl.haddr  = lsuGrant ? lsuReq.addr : ifuReq.addr;
    ctrl.hwrite = (nextState == MemWrite);
    // Fetches are always full 32-bit words
    ctrl.hsize  = lsuGrant ? lsuReq.size : SizeWord;
    ctrl.hburst = lsuGrant ? lsuReq.burst : ifuReq.burst;
    // Data access, privileged
    ctrl.hprot  = 4'b0011;
    // No owner, no transfer on the bus
    if (lsuGrant) begin
      ctrl.htrans = lsuReq.trans;
    end else if (nextState == InstrRead) begin
      ctrl.htrans = ifuReq.trans;
    end else begin
      ctrl.htrans = TransIdle;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data phase
  //////////////////////////////////////////////////////////////////////

  ahbWriteStage #(
    .DataBits (DataBits)
  ) writeStage_i (
    .clk      (clk),
    .arstN    (arstN),
    .capture  (lsuBusAck | lsuBusInit),
    .lsuWdata (lsuWdata),
    .addrLow  (ctrl.haddr[2:0]),
    .size     (ctrl.hsize),
    .write    (ctrl.hwrite),
    .hwdata   (hwdata),
    .hwstrb   (laneStrb),
    .writeD   (writeDataPhase)
  );

  // Strobes only mean something under a write data phase
  assign hwstrb = writeDataPhase ? laneStrb : '0;

  //////////////////////////////////////////////////////////////////////
  // Requester feedback
  //////////////////////////////////////////////////////////////////////

  assign lsuOwned = (state == MemRead) || (state == MemWrite);
  assign ifuOwned = (state == InstrRead);

  // Init marks the first address phase of a new owner
  assign ifuBusInit = !ifuOwned && (nextState == InstrRead);
  assign lsuBusInit = (state != MemRead && nextState == MemRead) ||
                      (state != MemWrite && nextState == MemWrite);

  // One data beat done per ready cycle of the owner
  assign ifuBusAck = hready && ifuOwned;
  assign lsuBusAck = hready && lsuOwned;

  // A rising ack goes to a requester still asking for the bus
  lsuAckOwnerA: assert property (@(posedge clk) disable iff (!arstN)
    $rose(lsuBusAck) |-> (lsuBusRead || lsuBusWrite))
    else $error("lsu ack without ownership");

  ifuAckOwnerA: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ifuBusAck) |-> ifuBusRead)
    else $error("ifu ack without ownership");

endmodule

// ==== src/ahbPkg.sv ====
// AHB-Lite bus definitions
// Shared enums, control structs and fixed widths for the external bus unit

package ahbPkg;

  //////////////////////////////////////////////////////////////////////
  // Fixed bus widths
  //////////////////////////////////////////////////////////////////////

  // HADDR width, 32-bit addressed bus
  localparam int AhbAddrBits = 32;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Bus owner, data streams ahead of instruction fetch
  typedef enum logic [1:0] {Idle, MemRead, MemWrite, InstrRead} busStateT;

  // HTRANS encoding per AHB-Lite
  typedef enum logic [1:0] {TransIdle, TransBusy, TransNonSeq, TransSeq} hTransT;

  // HBURST subset, only SINGLE and INCR4 are in use
  typedef enum logic [2:0] {BurstSingle, BurstIncr, BurstWrap4, BurstIncr4} hBurstT;

  // HSIZE, bytes per beat is 1 << hsize
  typedef enum logic [2:0] {SizeByte, SizeHalf, SizeWord, SizeDouble} hSizeT;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Address-phase control from manager to subordinate
  typedef struct packed {
    logic [AhbAddrBits-1:0] haddr;
    logic                   hwrite;
    hSizeT                  hsize;
    hBurstT                 hburst;
    hTransT                 htrans;
    logic [3:0]             hprot;
  } ahbCtrlT;

  // One requester's address-phase request
  typedef struct packed {
    logic [AhbAddrBits-1:0] addr;
    hSizeT                  size;
    hBurstT                 burst;
    hTransT                 trans;
  } busReqT;

endpackage

// ==== src/ahbSram.sv ====
// AHB-Lite SRAM subordinate
// Fixed wait states per data phase, byte-strobed writes, always OKAY

`timescale 1ns/1ps

module ahbSram import ahbPkg::*; #(
  parameter int DataBits   = 32,
  parameter int WaitStates = 1,
  // Power of two, the word index wraps
  parameter int MemWords   = 256
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  ahbCtrlT               ctrl,
  input  logic [DataBits-1:0]   hwdata,
  input  logic [DataBits/8-1:0] hwstrb,
  output logic                  hready,
  output logic [DataBits-1:0]   hrdata
);

  localparam int StrbBits = DataBits / 8;
  localparam int OffBits  = $clog2(StrbBits);
  localparam int IdxBits  = $clog2(MemWords);
  // Counter needs one bit even with no wait states
  localparam int CntBits  = (WaitStates > 0) ? $clog2(WaitStates + 1) : 1;

  logic [DataBits-1:0] mem [MemWords];

  logic               pending;
  logic               writeP;
  logic [CntBits-1:0] waitCnt;
  logic [IdxBits-1:0] addrP;
  logic               addrAccept;
  logic               dataEnd;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  // Ready unless a data phase still has wait cycles left
  assign hready  = !pending || (waitCnt == '0);
  assign dataEnd = pending && (waitCnt == '0);

  // Only NONSEQ and SEQ carry a transfer
  assign addrAccept = hready &&
                      ((ctrl.htrans == TransNonSeq) || (ctrl.htrans == TransSeq));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pending <= 1'b0;
      writeP  <= 1'b0;
      waitCnt <= '0;
    end else if (addrAccept) begin
      // New data phase, possibly right behind the last one
      pending <= 1'b1;
      writeP  <= ctrl.hwrite;
      waitCnt <= CntBits'(WaitStates);
    end else if (hready) begin
      pending <= 1'b0;
    end else begin
      waitCnt <= waitCnt - 1'b1;
    end
  end

  // Word index, upper address bits dropped
  always_ff @(posedge clk) begin
    if (addrAccept) begin
      addrP <= ctrl.haddr[OffBits +: IdxBits];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data phase
  //////////////////////////////////////////////////////////////////////

  // Strobed bytes land on the last cycle of a write data phase
  always_ff @(posedge clk) begin
    if (dataEnd && writeP) begin
      for (int lane = 0; lane < StrbBits; lane++) begin
        if (hwstrb[lane]) begin
          mem[addrP][lane*8 +: 8] <= hwdata[lane*8 +: 8];
        end
      end
    end
  end

  // Read word straight from the array
  // A write ending on the accept edge is already visible here
  assign hrdata = mem[addrP];

  // A stalled address phase has to be held by the manager
  ctrlHoldA: assert property (@(posedge clk) disable iff (!arstN)
    (!hready && (ctrl.htrans == TransNonSeq || ctrl.htrans == TransSeq))
    |=> $stable(ctrl))
    else $error("address phase changed under wait state");

endmodule

// ==== src/ahbSubsystem.sv ====
// AHB-Lite subsystem top
// Bus unit with a wait-state SRAM closing the bus, requesters outside

`timescale 1ns/1ps

module ahbSubsystem import ahbPkg::*; #(
  parameter int DataBits   = 32,
  parameter int WaitStates = 1,
  parameter int MemWords   = 256
) (
  input  logic                clk,
  input  logic                arstN,
  // Instruction fetch requester
  input  busReqT              ifuReq,
  input  logic                ifuBusRead,
  input  logic                ifuTransComplete,
  output logic                ifuBusInit,
  output logic                ifuBusAck,
  // Load/store requester
  input  busReqT              lsuReq,
  input  logic [DataBits-1:0] lsuWdata,
  input  logic                lsuBusRead,
  input  logic                lsuBusWrite,
  input  logic                lsuTransComplete,
  output logic                lsuBusInit,
  output logic                lsuBusAck,
  // Read data back to both requesters
  output logic [DataBits-1:0] hrdata
);

  // Internal AHB-Lite bus
  ahbCtrlT               ctrl;
  logic [DataBits-1:0]   hwdata;
  logic [DataBits/8-1:0] hwstrb;
  logic                  hready;

  ahbBusUnit #(
    .DataBits (DataBits)
  ) busUnit_i (
    .clk              (clk),
    .arstN            (arstN),
    .ifuReq           (ifuReq),
    .ifuBusRead       (ifuBusRead),
    .ifuTransComplete (ifuTransComplete),
    .ifuBusInit       (ifuBusInit),
    .ifuBusAck        (ifuBusAck),
    .lsuReq           (lsuReq),
    .lsuWdata         (lsuWdata),
    .lsuBusRead       (lsuBusRead),
    .lsuBusWrite      (lsuBusWrite),
    .lsuTransComplete (lsuTransComplete),
    .lsuBusInit       (lsuBusInit),
    .lsuBusAck        (lsuBusAck),
    .hready           (hready),
    .ctrl             (ctrl),
    .hwdata           (hwdata),
    .hwstrb           (hwstrb)
  );

  ahbSram #(
    .DataBits   (DataBits),
    .WaitStates (WaitStates),
    .MemWords   (MemWords)
  ) sram_i (
    .clk    (clk),
    .arstN  (arstN),
    .ctrl   (ctrl),
    .hwdata (hwdata),
    .hwstrb (hwstrb),
    .hready (hready),
    .hrdata (hrdata)
  );

endmodule

// ==== src/ahbWriteStage.sv ====
// AHB-Lite write data-phase stage
// Delays write data, low address bits, size and write flag by one cycle
// and derives the byte-lane strobes for the data phase

`timescale 1ns/1ps

module ahbWriteStage import ahbPkg::*; #(
  parameter int DataBits = 32
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  capture,
  input  logic [DataBits-1:0]   lsuWdata,
  input  logic [2:0]            addrLow,
  input  hSizeT                 size,
  input  logic                  write,
  output logic [DataBits-1:0]   hwdata,
  output logic [DataBits/8-1:0] hwstrb,
  output logic                  writeD
);

  // Byte lanes and the address bits that select one
  localparam int StrbBits = DataBits / 8;
  localparam int OffBits  = $clog2(StrbBits);

  logic [OffBits-1:0]  addrD;
  hSizeT               sizeD;
  logic [StrbBits-1:0] laneMask;

  //////////////////////////////////////////////////////////////////////
  // Data-phase registers
  //////////////////////////////////////////////////////////////////////

  // Write data follows the requester only on init or ack
  always_ff @(posedge clk) begin
    if (capture) begin
      hwdata <= lsuWdata;
    end
  end

  // Address-phase side info, taken every cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      addrD  <= '0;
      sizeD  <= SizeByte;
      writeD <= 1'b0;
    end else begin
      addrD  <= addrLow[OffBits-1:0];
      sizeD  <= size;
      writeD <= write;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte strobes
  //////////////////////////////////////////////////////////////////////

  // Contiguous ones for the access size, clipped to the bus width
  always_comb begin
    laneMask = StrbBits'((32'd1 << (32'd1 << sizeD)) - 32'd1);
    // Then moved up to the addressed lane
    hwstrb   = laneMask << addrD;
  end

  // A word store reaching the data phase sits on a word boundary
  wordAlignA: assert property (@(posedge clk) disable iff (!arstN)
    (write && size == SizeWord) |=> (addrD[1:0] == 2'b00))
    else $error("misaligned word access in data phase");

endmodule

// ==== tests/tbAhbSubsystem.sv ====
// Testbench for the AHB-Lite subsystem
// Plays the IFU and LSU requesters against a byte-wide reference memory
// and checks grants, latency and data with concurrent assertions

`timescale 1ns/1ps

module tbAhbSubsystem import ahbPkg::*;;

  localparam int DataBits   = 32;
  localparam int WaitStates = 1;
  localparam int MemWords   = 256;
  localparam int RefBytes   = MemWords * 4;
  localparam int RefIdxBits = $clog2(RefBytes);
  // Per round: 4 word writes, 4 byte writes, 4 reads, 2 pairs of mixed requests
  localparam int Rounds     = 4;
  localparam int NumTrans   = Rounds * 16;
  localparam int WatchdogCycles = NumTrans * (4 * (WaitStates + 1) + 4) + 100;

  logic                clk = 1'b0;
  logic                arstN;
  busReqT              ifuReq;
  logic                ifuBusRead;
  logic                ifuTransComplete;
  logic                ifuBusInit;
  logic                ifuBusAck;
  busReqT              lsuReq;
  logic [DataBits-1:0] lsuWdata;
  logic                lsuBusRead;
  logic                lsuBusWrite;
  logic                lsuTransComplete;
  logic                lsuBusInit;
  logic                lsuBusAck;
  logic [DataBits-1:0] hrdata;

  // Expected values, updated on rising edges only
  logic [31:0] lsuExpData;
  logic [3:0]  lsuExpStrb;
  logic        lsuIsWrite;
  logic [31:0] ifuExpData;
  int          ifuBeats;
  int          ifuAckCnt;

  logic [7:0] refMem [RefBytes];
  int         errorCount = 0;
  int         seed = 32'h2721_0739;

  always #10 clk = ~clk;

  ahbSubsystem #(
    .DataBits   (DataBits),
    .WaitStates (WaitStates),
    .MemWords   (MemWords)
  ) ahbSubsystem_i (
    .clk              (clk),
    .arstN            (arstN),
    .ifuReq           (ifuReq),
    .ifuBusRead       (ifuBusRead),
    .ifuTransComplete (ifuTransComplete),
    .ifuBusInit       (ifuBusInit),
    .ifuBusAck        (ifuBusAck),
    .lsuReq           (lsuReq),
    .lsuWdata         (lsuWdata),
    .lsuBusRead       (lsuBusRead),
    .lsuBusWrite      (lsuBusWrite),
    .lsuTransComplete (lsuTransComplete),
    .lsuBusInit       (lsuBusInit),
    .lsuBusAck        (lsuBusAck),
    .hrdata           (hrdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference memory
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] refWord(input logic [31:0] addr);
    logic [RefIdxBits-3:0] w;
    w = addr[RefIdxBits-1:2];
    return {refMem[{w, 2'd3}], refMem[{w, 2'd2}], refMem[{w, 2'd1}], refMem[{w, 2'd0}]};
  endfunction

  // Byte stores take the lane picked by the low address bits
  function automatic void refStore(input logic [31:0] addr, input hSizeT size,
                                   input logic [31:0] data);
    logic [RefIdxBits-3:0] w;
    w = addr[RefIdxBits-1:2];
    if (size == SizeByte) begin
      refMem[addr[RefIdxBits-1:0]] = data[8*addr[1:0] +: 8];
    end else begin
      for (int b = 0; b < 4; b++) begin
        refMem[{w, 2'(b)}] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic flagError(input string msg);
    errorCount++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Requester models
  //////////////////////////////////////////////////////////////////////

  // One SINGLE load or store, completion timed to the last ack
  task automatic lsuAccess(input logic isWrite, input logic [31:0] addr,
                           input hSizeT size, input logic [31:0] data);
    logic seen;
    @(posedge clk);
    lsuReq      <= '{addr: addr, size: size, burst: BurstSingle, trans: TransNonSeq};
    lsuWdata    <= data;
    lsuBusWrite <= isWrite;
    lsuBusRead  <= !isWrite;
    lsuIsWrite  <= isWrite;
    lsuExpData  <= refWord(addr);
    lsuExpStrb  <= (size == SizeByte) ? (4'b0001 << addr[1:0]) : 4'b1111;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = lsuBusInit;
    end
    // Only one address phase for a SINGLE
    @(posedge clk);
    lsuReq.trans <= TransIdle;
    repeat (WaitStates) @(posedge clk);
    lsuTransComplete <= 1'b1;
    @(posedge clk);
    lsuTransComplete <= 1'b0;
    lsuBusRead       <= 1'b0;
    lsuBusWrite      <= 1'b0;
    if (isWrite) refStore(addr, size, data);
  endtask

  // Instruction read, next address goes out after init or each ack
  task automatic ifuRead(input logic [31:0] addr, input int beats);
    logic seen;
    logic accepted;
    int   issued;
    int   acks;
    int   cyc;
    @(posedge clk);
    ifuReq     <= '{addr: addr, size: SizeWord,
                    burst: (beats == 1) ? BurstSingle : BurstIncr4, trans: TransNonSeq};
    ifuBusRead <= 1'b1;
    ifuBeats   <= beats;
    ifuExpData <= refWord(addr);
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = ifuBusInit;
    end
    accepted = 1'b1;
    issued   = 1;
    acks     = 0;
    cyc      = 0;
    while (acks < beats) begin
      @(posedge clk);
      cyc++;
      if (accepted && issued < beats) begin
        ifuReq.addr  <= addr + 32'(4 * issued);
        ifuReq.trans <= TransSeq;
        issued++;
      end else if (accepted) begin
        ifuReq.trans <= TransIdle;
      end
      ifuExpData       <= refWord(addr + 32'(4 * acks));
      ifuTransComplete <= (acks == beats - 1) && (cyc == WaitStates + 1);
      @(negedge clk);
      accepted = ifuBusAck;
      if (ifuBusAck) begin
        acks++;
        cyc = 0;
      end
    end
    @(posedge clk);
    ifuTransComplete <= 1'b0;
    ifuBusRead       <= 1'b0;
    ifuReq.trans     <= TransIdle;
  endtask

  task automatic waitIfuGrant();
    logic seen;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      seen = ifuBusInit;
    end
  endtask

  // Acks of the current instruction read before this cycle
  always @(negedge clk or negedge arstN) begin
    if (!arstN) begin
      ifuAckCnt <= 0;
    end else if (ifuBusInit) begin
      ifuAckCnt <= 0;
    end else if (ifuBusAck) begin
      ifuAckCnt <= ifuAckCnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks, sampled mid-cycle where everything is settled
  //////////////////////////////////////////////////////////////////////

  idleQuietA: assert property (@(negedge clk) disable iff (!arstN)
    (ahbSubsystem_i.busUnit_i.state == Idle && !ifuBusRead && !lsuBusRead && !lsuBusWrite)
    |-> (!ifuBusInit && !lsuBusInit && ahbSubsystem_i.ctrl.htrans == TransIdle))
    else flagError("grant or transfer with no request pending");
  idleNoAckA: assert property (@(negedge clk) disable iff (!arstN)
    (ahbSubsystem_i.busUnit_i.state == Idle) |-> (!ifuBusAck && !lsuBusAck))
    else flagError("ack while the bus is idle");
  // One owner at a time
  ackExclusiveA: assert property (@(negedge clk) disable iff (!arstN)
    !(ifuBusAck && lsuBusAck))
    else flagError("both requesters acknowledged in one cycle");
  lsuReadDataA: assert property (@(negedge clk) disable iff (!arstN)
    (lsuBusAck && !lsuIsWrite) |-> (hrdata == lsuExpData))
    else flagError("LSU read data differs from reference memory");
  lsuStrobeA: assert property (@(negedge clk) disable iff (!arstN)
    (lsuBusAck && lsuIsWrite) |-> (ahbSubsystem_i.hwstrb == lsuExpStrb))
    else flagError("write strobes do not match size and address");
  lsuDoneAckA: assert property (@(negedge clk) disable iff (!arstN)
    lsuTransComplete |-> lsuBusAck)
    else flagError("LSU ack missing in its completing cycle");
  // Loads and stores win from idle
  priorityA: assert property (@(negedge clk) disable iff (!arstN)
    (ahbSubsystem_i.busUnit_i.state == Idle && (lsuBusRead || lsuBusWrite) && ifuBusRead)
    |-> (lsuBusInit && !ifuBusInit))
    else flagError("IFU granted over a waiting LSU request");
  handToIfuA: assert property (@(negedge clk) disable iff (!arstN)
    (lsuTransComplete && ifuBusRead) |-> ifuBusInit)
    else flagError("IFU not granted in the LSU completing cycle");
  noPreemptA: assert property (@(negedge clk) disable iff (!arstN)
    (ahbSubsystem_i.busUnit_i.state == InstrRead && !ifuTransComplete) |-> !lsuBusInit)
    else flagError("LSU granted during an instruction read");
  handToLsuA: assert property (@(negedge clk) disable iff (!arstN)
    (ifuTransComplete && (lsuBusRead || lsuBusWrite)) |-> lsuBusInit)
    else flagError("LSU not granted in the IFU completing cycle");
  ifuDataA: assert property (@(negedge clk) disable iff (!arstN)
    ifuBusAck |-> (hrdata == ifuExpData))
    else flagError("IFU beat data differs from reference memory");
  ifuBeatsA: assert property (@(negedge clk) disable iff (!arstN)
    ifuTransComplete |-> (ifuBusAck && ifuAckCnt == ifuBeats - 1))
    else flagError("IFU burst ended with the wrong number of acks");
  // SINGLE ack exactly WaitStates+1 edges after init
  latencyA: assert property (@(negedge clk) disable iff (!arstN)
    $past(lsuBusInit, WaitStates + 1) |-> lsuBusAck)
    else flagError("LSU ack late");
  earlyAckA: assert property (@(negedge clk) disable iff (!arstN)
    $past(lsuBusInit) |-> (WaitStates == 0 || !lsuBusAck))
    else flagError("LSU ack early");

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] base;
    arstN            = 1'b0;
    ifuReq           = '{addr: '0, size: SizeWord, burst: BurstSingle, trans: TransIdle};
    lsuReq           = '{addr: '0, size: SizeWord, burst: BurstSingle, trans: TransIdle};
    ifuBusRead       = 1'b0;
    ifuTransComplete = 1'b0;
    lsuWdata         = '0;
    lsuBusRead       = 1'b0;
    lsuBusWrite      = 1'b0;
    lsuTransComplete = 1'b0;
    lsuExpData       = '0;
    lsuExpStrb       = '0;
    lsuIsWrite       = 1'b0;
    ifuExpData       = '0;
    ifuBeats         = 1;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    // Quiet bus after reset
    repeat (5) @(posedge clk);
    for (int r = 0; r < Rounds; r++) begin
      base = $random(seed) & 32'hFFFF_FFF0;
      for (int w = 0; w < 4; w++) begin
        lsuAccess(1'b1, base + 32'(4 * w), SizeWord, $random(seed));
      end
      for (int b = 0; b < 4; b++) begin
        lsuAccess(1'b1, base + ($random(seed) & 32'hF), SizeByte, $random(seed));
      end
      for (int w = 0; w < 4; w++) begin
        lsuAccess(1'b0, base + 32'(4 * w), SizeWord, '0);
      end
      // Both requesters in the same idle cycle
      fork
        lsuAccess(1'b0, base + 32'(4 * (r % 4)), SizeWord, '0);
        ifuRead(base, 4);
      join
      // Load raised in the middle of a fetch burst
      fork
        ifuRead(base, 4);
        begin
          waitIfuGrant();
          repeat (2) @(posedge clk);
          lsuAccess(1'b0, base + 32'h8, SizeWord, '0);
        end
      join
    end
    repeat (4) @(posedge clk);
    $display("Run complete, %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d clock cycles", WatchdogCycles);
    $display("tests failed");
    $finish;
  end

endmodule
